//--- common/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath word
`define DATA_W 32

// 32 architectural registers
`define REG_AW 5

// word addresses into instruction and data memory
`define IM_AW 10
`define DM_AW 12

`define RESET_PC 0

`endif

//--- common/core_pkg.sv
`default_nettype none

`include "core_defines.svh"

package core_pkg;

	typedef enum logic [2:0] {
		ph_fetch,
		ph_decode,
		ph_execute,
		ph_memaccess,
		ph_writeback
	} phase_e;

	// instruction bits 31..26
	typedef enum logic [5:0] {
		op_alu  = 6'h00,
		op_addi = 6'h01,
		op_movi = 6'h02,
		op_lw   = 6'h03,
		op_sw   = 6'h04,
		op_beq  = 6'h05,
		op_j    = 6'h06,
		op_nop  = 6'h3f
	} opcode_e;

	// instruction bits 2..0 for op_alu
	typedef enum logic [2:0] {
		alu_add    = 3'd0,
		alu_sub    = 3'd1,
		alu_and    = 3'd2,
		alu_or     = 3'd3,
		alu_xor    = 3'd4,
		alu_slt    = 3'd5,
		alu_pass_b = 3'd6
	} alu_op_e;

	typedef struct packed {
		opcode_e             opcode;
		alu_op_e             alu_op;
		logic [`REG_AW-1:0]  rt_addr;
		logic                src2_imm;
		// already extended
		logic [`DATA_W-1:0]  imm;
		logic                do_reg_write;
		logic                do_dm_read;
		logic                do_dm_write;
	} decoded_t;

	typedef struct packed {
		logic [`DATA_W-1:0] ra_data;
		logic [`DATA_W-1:0] rt_data;
	} operands_t;

	typedef struct packed {
		decoded_t  dec;
		operands_t ops;
	} exec_t;

endpackage

`default_nettype wire

//--- controller/controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module controller
	import core_pkg::*;
(
	input  logic                 enable_memaccess,
	input  logic                 rst_n,
	input  logic [`DATA_W-1:0]   instruction,
	input  opcode_e              exec_opcode,
	output logic                 fetch_en,
	output logic                 decode_en,
	output logic                 exec_en,
	output logic                 mem_phase,
	output logic                 wb_en,
	output logic                 IM_enable,
	output logic                 IM_read,
	output logic                 IM_write,
	output logic                 DM_enable,
	output logic                 DM_read,
	output logic                 DM_write,
	output logic [`REG_AW-1:0]   ra_addr,
	output logic [`REG_AW-1:0]   rb_addr,
	output decoded_t             decoded
);

	phase_e              phase_q;
	logic                idle_q;
	logic [`DATA_W-1:0]  ir_q;

	// reset parks in writeback with every strobe low
	always_ff @(posedge enable_memaccess) begin
		if (!rst_n) begin
			phase_q <= ph_writeback;
			idle_q  <= 1'b1;
		end else begin
			idle_q <= 1'b0;
			case (phase_q)
				ph_fetch:     phase_q <= ph_decode;
				ph_decode:    phase_q <= ph_execute;
				ph_execute:   phase_q <= ph_memaccess;
				ph_memaccess: phase_q <= ph_writeback;
				default:      phase_q <= ph_fetch;
			endcase
		end
	end

	always_ff @(posedge enable_memaccess) begin
		if (fetch_en) begin
			ir_q <= instruction;
		end
	end

	assign fetch_en  = (phase_q == ph_fetch);
	assign decode_en = (phase_q == ph_decode);
	assign exec_en   = (phase_q == ph_execute);
	assign mem_phase = (phase_q == ph_memaccess);
	assign wb_en     = (phase_q == ph_writeback) && !idle_q;

	assign IM_enable = fetch_en;
	assign IM_read   = fetch_en;
	assign IM_write  = 1'b0;
	assign DM_enable = mem_phase;
	assign DM_read   = mem_phase && (exec_opcode == op_lw);
	assign DM_write  = mem_phase && (exec_opcode == op_sw);

	assign ra_addr = ir_q[20:16];

	always_comb begin
		decoded         = '0;
		decoded.opcode  = op_nop;
		decoded.alu_op  = alu_pass_b;
		decoded.rt_addr = ir_q[25:21];
		rb_addr         = ir_q[15:11];
		case (ir_q[31:26])
			op_alu: begin
				decoded.opcode       = op_alu;
				decoded.alu_op       = alu_op_e'(ir_q[2:0]);
				decoded.do_reg_write = 1'b1;
			end
			op_addi, op_lw, op_sw: begin
				decoded.opcode       = opcode_e'(ir_q[31:26]);
				decoded.alu_op       = alu_add;
				decoded.src2_imm     = 1'b1;
				decoded.imm          = {{(`DATA_W-15){ir_q[14]}}, ir_q[14:0]};
				decoded.do_reg_write = (ir_q[31:26] != op_sw);
				decoded.do_dm_read   = (ir_q[31:26] == op_lw);
				decoded.do_dm_write  = (ir_q[31:26] == op_sw);
				// store data is rt, read through port b
				if (ir_q[31:26] == op_sw) begin
					rb_addr = ir_q[25:21];
				end
			end
			op_movi: begin
				decoded.opcode       = op_movi;
				decoded.src2_imm     = 1'b1;
				decoded.imm          = {{(`DATA_W-20){1'b0}}, ir_q[19:0]};
				decoded.do_reg_write = 1'b1;
			end
			op_beq: begin
				decoded.opcode = op_beq;
				decoded.imm    = {{(`DATA_W-14){ir_q[13]}}, ir_q[13:0]};
				rb_addr        = ir_q[25:21];
			end
			op_j: begin
				decoded.opcode = op_j;
				decoded.imm    = {{(`DATA_W-`IM_AW){1'b0}}, ir_q[`IM_AW-1:0]};
			end
			default: ;
		endcase
	end

	a_one_phase: assert property (@(posedge enable_memaccess) disable iff (!rst_n)
		!idle_q |-> $onehot({fetch_en, decode_en, exec_en, mem_phase, wb_en}));

	a_dm_excl: assert property (@(posedge enable_memaccess) disable iff (!rst_n)
		!(DM_read && DM_write));

endmodule

`default_nettype wire

//--- hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module regfile
	import core_pkg::*;
(
	input  logic                 enable_memaccess,
	input  logic                 rst_n,
	input  logic [`REG_AW-1:0]   ra_addr,
	input  logic [`REG_AW-1:0]   rb_addr,
	input  logic                 wb_en,
	input  exec_t                exec,
	input  logic [`DATA_W-1:0]   wb_data,
	output operands_t            operands,
	output logic [`DATA_W-1:0]   rb_data
);

	localparam int NUM_REGS = 1 << `REG_AW;

	logic [`DATA_W-1:0]  regs [NUM_REGS];
	logic                wr_en;
	logic [`REG_AW-1:0]  wr_addr;
	logic [`DATA_W-1:0]  rd_a;
	logic [`DATA_W-1:0]  rd_b;

	// r0 is never written
	assign wr_addr = exec.dec.rt_addr;
	assign wr_en   = wb_en && exec.dec.do_reg_write && (wr_addr != '0);

	always_ff @(posedge enable_memaccess) begin
		if (wr_en) begin
			regs[wr_addr] <= wb_data;
		end
	end

	assign rd_a = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rd_b = (rb_addr == '0) ? '0 : regs[rb_addr];

	assign operands.ra_data = rd_a;
	assign operands.rt_data = rd_b;
	assign rb_data          = rd_b;

	a_r0_zero: assert property (@(posedge enable_memaccess) disable iff (!rst_n)
		(wb_en && exec.dec.do_reg_write && (exec.dec.rt_addr == '0))
		|=> (regs[0] === $past(regs[0])));

endmodule

`default_nettype wire

//--- hw/stage_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module stage_regs
	import core_pkg::*;
(
	input  logic                 enable_memaccess,
	input  logic                 rst_n,
	input  logic                 decode_en,
	input  decoded_t             decoded,
	input  operands_t            operands,
	input  logic [`DATA_W-1:0]   rb_data,
	output exec_t                exec
);

	always_ff @(posedge enable_memaccess) begin
		if (!rst_n) begin
			exec.dec.do_reg_write <= 1'b0;
			exec.dec.do_dm_read   <= 1'b0;
			exec.dec.do_dm_write  <= 1'b0;
		end else if (decode_en) begin
			exec.dec         <= decoded;
			exec.ops.ra_data <= operands.ra_data;
			// port b is switched to rt for stores and branches
			exec.ops.rt_data <= rb_data;
		end
	end

endmodule

`default_nettype wire

//--- alu/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module execute_unit
	import core_pkg::*;
(
	input  logic                 enable_memaccess,
	input  logic                 rst_n,
	input  logic                 exec_en,
	input  logic                 mem_phase,
	input  exec_t                exec,
	input  logic [`DATA_W-1:0]   DM_out,
	output logic [`DATA_W-1:0]   result_q,
	output logic                 alu_overflow,
	output logic                 alu_zero,
	output logic [`DATA_W-1:0]   wb_data
);

	logic [`DATA_W-1:0]  src_a;
	logic [`DATA_W-1:0]  src_b;
	logic [`DATA_W-1:0]  sum;
	logic [`DATA_W-1:0]  alu_y;
	logic [`DATA_W-1:0]  load_q;
	logic                lt;
	logic                ovf;
	logic                arith;

	assign src_a = exec.ops.ra_data;
	assign src_b = exec.dec.src2_imm ? exec.dec.imm : exec.ops.rt_data;

	assign sum = (exec.dec.alu_op == alu_sub) ? src_a - src_b : src_a + src_b;
	assign lt  = $signed(src_a) < $signed(src_b);

	always_comb begin
		case (exec.dec.alu_op)
			alu_add, alu_sub: alu_y = sum;
			alu_and:          alu_y = src_a & src_b;
			alu_or:           alu_y = src_a | src_b;
			alu_xor:          alu_y = src_a ^ src_b;
			alu_slt:          alu_y = {{(`DATA_W-1){1'b0}}, lt};
			alu_pass_b:       alu_y = src_b;
			default:          alu_y = '0;
		endcase
	end

	// signed overflow, only reported for add, addi and sub
	always_comb begin
		case (exec.dec.alu_op)
			alu_add: ovf = (src_a[`DATA_W-1] == src_b[`DATA_W-1]) &&
				(sum[`DATA_W-1] != src_a[`DATA_W-1]);
			alu_sub: ovf = (src_a[`DATA_W-1] != src_b[`DATA_W-1]) &&
				(sum[`DATA_W-1] != src_a[`DATA_W-1]);
			default: ovf = 1'b0;
		endcase
	end
	assign arith = (exec.dec.opcode == op_alu) || (exec.dec.opcode == op_addi);

	always_ff @(posedge enable_memaccess) begin
		if (!rst_n) begin
			alu_overflow <= 1'b0;
		end else if (exec_en) begin
			alu_overflow <= arith && ovf;
		end
	end

	always_ff @(posedge enable_memaccess) begin
		if (exec_en) begin
			result_q <= alu_y;
		end
		if (mem_phase && exec.dec.do_dm_read) begin
			load_q <= DM_out;
		end
	end

	assign alu_zero = (exec.ops.ra_data == exec.ops.rt_data);
	assign wb_data  = (exec.dec.opcode == op_lw) ? load_q : result_q;

	a_no_logic_ovf: assert property (@(posedge enable_memaccess) disable iff (!rst_n)
		exec_en && !(exec.dec.alu_op inside {alu_add, alu_sub}) |=> !alu_overflow);

endmodule

`default_nettype wire

//--- hw/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module pc_unit
	import core_pkg::*;
(
	input  logic                 enable_memaccess,
	input  logic                 rst_n,
	input  logic                 exec_en,
	input  exec_t                exec,
	input  logic                 alu_zero,
	output logic [`IM_AW-1:0]    current_pc
);

	logic [`IM_AW-1:0] next_pc;

	// wraps at the top of instruction memory
	always_comb begin
		next_pc = current_pc + 1'b1;
		case (exec.dec.opcode)
			op_beq: begin
				if (alu_zero) begin
					next_pc = current_pc + exec.dec.imm[`IM_AW-1:0];
				end
			end
			op_j:    next_pc = exec.dec.imm[`IM_AW-1:0];
			default: ;
		endcase
	end

	always_ff @(posedge enable_memaccess) begin
		if (!rst_n) begin
			current_pc <= `IM_AW'(`RESET_PC);
		end else if (exec_en) begin
			current_pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

//--- hw/core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_top
	import core_pkg::*;
(
	input  logic                 enable_memaccess,
	input  logic                 rst_n,
	input  logic [`DATA_W-1:0]   instruction,
	output logic                 alu_overflow,

	output logic                 IM_read,
	output logic                 IM_write,
	output logic                 IM_enable,
	output logic [`IM_AW-1:0]    IM_address,

	output logic                 DM_read,
	output logic                 DM_write,
	output logic                 DM_enable,
	output logic [`DM_AW-1:0]    DM_address,
	output logic [`DATA_W-1:0]   DM_in,
	input  logic [`DATA_W-1:0]   DM_out
);

	logic                decode_en;
	logic                exec_en;
	logic                mem_phase;
	logic                wb_en;
	logic [`REG_AW-1:0]  ra_addr;
	logic [`REG_AW-1:0]  rb_addr;
	decoded_t            decoded;
	operands_t           operands;
	logic [`DATA_W-1:0]  rb_data;
	exec_t               exec;
	logic [`DATA_W-1:0]  result_q;
	logic [`DATA_W-1:0]  wb_data;
	logic                alu_zero;
	logic [`IM_AW-1:0]   current_pc;

	assign IM_address = current_pc;
	assign DM_address = result_q[`DM_AW-1:0];
	assign DM_in      = exec.ops.rt_data;

	// fetch strobe leaves the controller as IM_enable
	controller u_controller (
		.enable_memaccess (enable_memaccess),
		.rst_n            (rst_n),
		.instruction      (instruction),
		.exec_opcode      (exec.dec.opcode),
		.fetch_en         (),
		.decode_en        (decode_en),
		.exec_en          (exec_en),
		.mem_phase        (mem_phase),
		.wb_en            (wb_en),
		.IM_enable        (IM_enable),
		.IM_read          (IM_read),
		.IM_write         (IM_write),
		.DM_enable        (DM_enable),
		.DM_read          (DM_read),
		.DM_write         (DM_write),
		.ra_addr          (ra_addr),
		.rb_addr          (rb_addr),
		.decoded          (decoded)
	);

	regfile u_regfile (
		.enable_memaccess (enable_memaccess),
		.rst_n            (rst_n),
		.ra_addr          (ra_addr),
		.rb_addr          (rb_addr),
		.wb_en            (wb_en),
		.exec             (exec),
		.wb_data          (wb_data),
		.operands         (operands),
		.rb_data          (rb_data)
	);

	stage_regs u_stage_regs (
		.enable_memaccess (enable_memaccess),
		.rst_n            (rst_n),
		.decode_en        (decode_en),
		.decoded          (decoded),
		.operands         (operands),
		.rb_data          (rb_data),
		.exec             (exec)
	);

	execute_unit u_execute_unit (
		.enable_memaccess (enable_memaccess),
		.rst_n            (rst_n),
		.exec_en          (exec_en),
		.mem_phase        (mem_phase),
		.exec             (exec),
		.DM_out           (DM_out),
		.result_q         (result_q),
		.alu_overflow     (alu_overflow),
		.alu_zero         (alu_zero),
		.wb_data          (wb_data)
	);

	pc_unit u_pc_unit (
		.enable_memaccess (enable_memaccess),
		.rst_n            (rst_n),
		.exec_en          (exec_en),
		.exec             (exec),
		.alu_zero         (alu_zero),
		.current_pc       (current_pc)
	);

endmodule

`default_nettype wire

//--- verification/core_tb_program.svh
localparam int PROG_LEN = 51;

logic [31:0] prog [PROG_LEN];
int          exp_pc [1024];
logic        exp_ovf [1024];
logic [31:0] exp_st_addr [$];
logic [31:0] exp_st_data [$];
int          trace_len;

// architectural state of the ISA model
logic [31:0] mreg [32];
logic [31:0] mdm [4096];

function automatic logic [31:0] enc_alu(alu_op_e f, int rt, int ra, int rb);
	return {op_alu, rt[4:0], ra[4:0], rb[4:0], 8'h00, f};
endfunction

// addi, lw and sw share the imm15 layout
function automatic logic [31:0] enc_imm(opcode_e op, int rt, int ra, int imm);
	return {op, rt[4:0], ra[4:0], 1'b0, imm[14:0]};
endfunction

function automatic logic [31:0] enc_movi(int rt, int imm);
	return {op_movi, rt[4:0], 1'b0, imm[19:0]};
endfunction

function automatic logic [31:0] enc_beq(int rt, int ra, int off);
	return {op_beq, rt[4:0], ra[4:0], 2'b00, off[13:0]};
endfunction

function automatic logic [31:0] enc_j(int target);
	return {op_j, 16'h0000, target[9:0]};
endfunction

task automatic load_program();
	prog[0]  = enc_movi(1, 'h12345);
	prog[1]  = enc_movi(2, 'h0abcd);
	prog[2]  = enc_alu(alu_add, 3, 1, 2);
	prog[3]  = enc_alu(alu_sub, 4, 2, 1);
	prog[4]  = enc_alu(alu_and, 5, 1, 2);
	prog[5]  = enc_alu(alu_or, 6, 1, 2);
	prog[6]  = enc_alu(alu_xor, 7, 1, 2);
	prog[7]  = enc_alu(alu_slt, 8, 4, 1);
	prog[8]  = enc_imm(op_sw, 3, 0, 16);
	prog[9]  = enc_imm(op_sw, 4, 0, 17);
	prog[10] = enc_imm(op_sw, 5, 0, 18);
	prog[11] = enc_imm(op_sw, 6, 0, 19);
	prog[12] = enc_imm(op_sw, 7, 0, 20);
	prog[13] = enc_imm(op_sw, 8, 0, 21);
	// loads from the random preload
	prog[14] = enc_imm(op_addi, 9, 0, 64);
	prog[15] = enc_imm(op_lw, 10, 9, 5);
	prog[16] = enc_imm(op_lw, 11, 9, -3);
	prog[17] = enc_alu(alu_add, 12, 10, 11);
	prog[18] = enc_alu(alu_add, 13, 10, 10);
	prog[19] = enc_alu(alu_sub, 14, 10, 11);
	prog[20] = enc_imm(op_sw, 12, 9, 32);
	prog[21] = enc_imm(op_sw, 13, 9, 33);
	prog[22] = enc_imm(op_sw, 14, 9, 34);
	// branch not taken, then taken over two stores
	prog[23] = enc_beq(1, 2, 5);
	prog[24] = enc_beq(10, 10, 3);
	prog[25] = enc_imm(op_sw, 1, 0, 48);
	prog[26] = enc_imm(op_sw, 2, 0, 49);
	prog[27] = enc_j(30);
	prog[28] = enc_imm(op_sw, 1, 0, 50);
	prog[29] = enc_imm(op_sw, 2, 0, 51);
	prog[30] = enc_imm(op_addi, 15, 9, -1);
	prog[31] = enc_beq(15, 9, -10);
	prog[32] = enc_imm(op_sw, 15, 0, 2047);
	prog[33] = enc_alu(alu_slt, 16, 1, 4);
	prog[34] = enc_imm(op_sw, 16, 0, 22);
	// countdown loop with a backward branch
	prog[35] = enc_movi(17, 3);
	prog[36] = enc_imm(op_addi, 17, 17, -1);
	prog[37] = enc_beq(17, 0, 2);
	prog[38] = enc_beq(0, 0, -2);
	prog[39] = enc_imm(op_sw, 17, 0, 23);
	// doubling until the sign bit flips, then a sub that overflows
	prog[40] = enc_movi(18, 'h80000);
	prog[41] = enc_movi(19, 12);
	prog[42] = enc_alu(alu_add, 18, 18, 18);
	prog[43] = enc_imm(op_addi, 19, 19, -1);
	prog[44] = enc_beq(19, 0, 2);
	prog[45] = enc_beq(0, 0, -3);
	prog[46] = enc_alu(alu_sub, 20, 0, 18);
	prog[47] = enc_imm(op_sw, 20, 0, 24);
	// r0 keeps reading zero after a write
	prog[48] = enc_imm(op_addi, 0, 18, 1);
	prog[49] = enc_imm(op_sw, 0, 0, 25);
	prog[50] = enc_j(50);
endtask

// runs imem until a jump to itself
task automatic run_model();
	logic [31:0] ins;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] t;
	logic [31:0] r;
	logic [31:0] simm;
	logic        wr;
	logic        ovf;
	int          pc;
	int          next_pc;
	int          n;
	int          i;
	bit          halted;
	for (i = 0; i < 32; i++) begin
		mreg[i] = '0;
	end
	for (i = 0; i < 4096; i++) begin
		mdm[i] = dm[i];
	end
	pc = 0;
	n = 0;
	halted = 1'b0;
	while (!halted && n < 1024) begin
		ins = imem[pc];
		a = mreg[ins[20:16]];
		b = mreg[ins[15:11]];
		t = mreg[ins[25:21]];
		simm = {{17{ins[14]}}, ins[14:0]};
		r = '0;
		wr = 1'b0;
		ovf = 1'b0;
		next_pc = (pc + 1) % 1024;
		exp_pc[n] = pc;
		case (ins[31:26])
			op_alu: begin
				wr = 1'b1;
				case (ins[2:0])
					alu_add: begin
						r = a + b;
						ovf = (a[31] == b[31]) && (r[31] != a[31]);
					end
					alu_sub: begin
						r = a - b;
						ovf = (a[31] != b[31]) && (r[31] != a[31]);
					end
					alu_and: r = a & b;
					alu_or:  r = a | b;
					alu_xor: r = a ^ b;
					alu_slt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: r = '0;
				endcase
			end
			op_addi: begin
				r = a + simm;
				ovf = (a[31] == simm[31]) && (r[31] != a[31]);
				wr = 1'b1;
			end
			op_movi: begin
				r = {12'h000, ins[19:0]};
				wr = 1'b1;
			end
			op_lw: begin
				r = a + simm;
				r = mdm[r[11:0]];
				wr = 1'b1;
			end
			op_sw: begin
				r = a + simm;
				mdm[r[11:0]] = t;
				exp_st_addr.push_back({20'h0, r[11:0]});
				exp_st_data.push_back(t);
			end
			op_beq: begin
				if (a == t) begin
					next_pc = (pc + {{18{ins[13]}}, ins[13:0]}) & 1023;
				end
			end
			op_j: begin
				next_pc = ins[9:0];
				halted = (next_pc == pc);
			end
			default: ;
		endcase
		if (wr && ins[25:21] != 5'd0) begin
			mreg[ins[25:21]] = r;
		end
		exp_ovf[n] = ovf;
		n++;
		pc = next_pc;
	end
	trace_len = n;
endtask

//--- verification/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb
	import core_pkg::*;
();

	logic         enable_memaccess;
	logic         rst_n;
	logic [31:0]  instruction;
	logic [31:0]  DM_out;
	logic         alu_overflow;
	logic         IM_read;
	logic         IM_write;
	logic         IM_enable;
	logic [9:0]   IM_address;
	logic         DM_read;
	logic         DM_write;
	logic         DM_enable;
	logic [11:0]  DM_address;
	logic [31:0]  DM_in;

	logic [31:0]  imem [1024];
	logic [31:0]  dm [4096];
	integer       seed;
	int           n_checks;
	int           n_errors;
	int           k;
	int           since_fetch;
	bit           finished;
	bit           model_ready;

	`include "core_tb_program.svh"

	core_top UUT (
		.enable_memaccess (enable_memaccess),
		.rst_n            (rst_n),
		.instruction      (instruction),
		.alu_overflow     (alu_overflow),
		.IM_read          (IM_read),
		.IM_write         (IM_write),
		.IM_enable        (IM_enable),
		.IM_address       (IM_address),
		.DM_read          (DM_read),
		.DM_write         (DM_write),
		.DM_enable        (DM_enable),
		.DM_address       (DM_address),
		.DM_in            (DM_in),
		.DM_out           (DM_out)
	);

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		assert (act === exp) else begin
			n_errors++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		n_checks++;
		assert (cond === 1'b1) else begin
			n_errors++;
			$display("error: %s", what);
		end
	endtask

	initial begin
		enable_memaccess = 1'b0;
		forever #10 enable_memaccess = ~enable_memaccess;
	end

	initial begin
		int i;
		rst_n = 1'b0;
		instruction = '0;
		DM_out = '0;
		seed = 32'hc4d9;
		load_program();
		// unused words hold a nop tagged with their address
		for (i = 0; i < 1024; i++) begin
			imem[i] = (i < PROG_LEN) ? prog[i] : {op_nop, 16'h0000, i[9:0]};
		end
		for (i = 0; i < 4096; i++) begin
			dm[i] = $random(seed);
		end
		run_model();
		model_ready = 1'b1;

		repeat (5) begin
			@(negedge enable_memaccess);
			check_value("enables in reset", 32'h0, {IM_enable, IM_read, IM_write,
				DM_enable, DM_read, DM_write, alu_overflow});
		end
		rst_n = 1'b1;

		k = -1;
		since_fetch = 0;
		while (!finished) begin
			@(negedge enable_memaccess);
			since_fetch++;
			check_true(!(DM_read && DM_write), "DM_read and DM_write are high together");
			check_true(!IM_write, "IM_write is asserted");
			if (IM_enable) begin
				k++;
				if (k > 0) begin
					check_value("cycles between fetches", 32'd5, since_fetch);
				end
				since_fetch = 0;
				check_true(IM_read, "IM_read is low during a fetch");
				check_value($sformatf("pc of step %0d", k), exp_pc[k], IM_address);
			end
			if (DM_enable) begin
				check_value($sformatf("overflow of step %0d", k), exp_ovf[k], alu_overflow);
				if (DM_write) begin
					if (exp_st_addr.size() == 0) begin
						check_true(1'b0, "a store happened where none was expected");
					end else begin
						check_value("store address", exp_st_addr.pop_front(), DM_address);
						check_value("store data", exp_st_data.pop_front(), DM_in);
					end
					dm[DM_address] = DM_in;
				end
				finished = (k == trace_len - 1);
			end
			instruction = IM_enable ? imem[IM_address] : '0;
			DM_out = (DM_enable && DM_read) ? dm[DM_address] : '0;
		end

		check_true(exp_st_addr.size() == 0, "some expected stores never happened");
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// five cycles per executed instruction, plus reset and slack
	initial begin
		wait (model_ready);
		#((trace_len * 5 + 25) * 20);
		$display("timeout: the core did not reach the last instruction in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+common
+incdir+verification
common/core_pkg.sv
controller/controller.sv
hw/regfile.sv
hw/stage_regs.sv
alu/execute_unit.sv
hw/pc_unit.sv
hw/core_top.sv
verification/core_tb.sv

//--- Bender.yml
package:
  name: core

export_include_dirs:
  - common

sources:
  - files:
      - common/core_pkg.sv
      - controller/controller.sv
      - hw/regfile.sv
      - hw/stage_regs.sv
      - alu/execute_unit.sv
      - hw/pc_unit.sv
      - hw/core_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/core_tb.sv
